//--- build.f
verilog/cachePkg.sv
verilog/ctrlPkg.sv
verilog/cacheArray.sv
verilog/wayLookup.sv
verilog/cacheControl.sv
verilog/dCache.sv
sim/tbMemory.sv
sim/tbDCache.sv

//--- sim/tbDCache.sv
`timescale 1ns/10ps

module tbDCache;

   localparam int CLK_PERIOD  = 8;
   localparam int HALF_PERIOD = CLK_PERIOD / 2;
   localparam int RESET_CYCLES = 16;
   localparam int MEM_WORDS   = 256;
   localparam int RANDOM_OPS  = 400;
   localparam int CYCLE_LIMIT = 20000;  // 400 requests x ~20 cycles, flush, margin

   // dhit expected in the request cycle, or not, or either
   localparam int EXPECT_MISS = 0;
   localparam int EXPECT_HIT  = 1;
   localparam int EXPECT_ANY  = 2;

   logic CLK;
   logic nRST;
   logic dmemREN, dmemWEN, halt;
   logic [31:0] dmemaddr, dmemstore, dmemload;
   logic dhit, flushed;
   logic dREN, dWEN, dwait;
   logic [31:0] daddr, dstore, dload;

   logic [31:0] shadow [MEM_WORDS];  // memory as the processor should see it
   string nameQ [$];
   logic [31:0] addrQ [$];
   logic [31:0] gotQ [$];
   event readSampled;
   int errorCount = 0;
   int checkCount = 0;
   int cycleCount = 0;
   logic [31:0] randWord;
   logic [31:0] randData;

   dCache dut_i (.*);

   tbMemory #(.WORDS(MEM_WORDS)) memory_i (.*);

   initial
   begin
      CLK = 1'b0;
      forever #(HALF_PERIOD) CLK = ~CLK;
   end

   always @(posedge CLK)
   begin
      cycleCount <= cycleCount + 1;
   end

   function automatic logic [31:0] expectedLoad(input logic [31:0] addr);
      return shadow[addr[9:2]];
   endfunction

   function automatic logic [31:0] blockAddr(input logic [25:0] tag, input logic [2:0] idx,
                                             input logic off);
      cachePkg::dAddr_u a;
      a.raw           = '0;
      a.fields.tag    = tag;
      a.fields.idx    = idx;
      a.fields.blkOff = off;
      return a.raw;
   endfunction

   // starts on a falling edge and ends on the falling edge after dhit
   task automatic issueRequest(input logic isWrite, input logic [31:0] addr,
                               input logic [31:0] data, input int hitMode,
                               input string name);
      logic served;
      logic firstLook;
      served    = 1'b0;
      firstLook = 1'b1;
      dmemREN   = !isWrite;
      dmemWEN   = isWrite;
      dmemaddr  = addr;
      dmemstore = data;
      while (!served)
      begin
         #(HALF_PERIOD - 1);  // just ahead of the rising edge
         if (firstLook && (hitMode != EXPECT_ANY))
         begin
            checkCount++;
            assert (dhit === (hitMode == EXPECT_HIT))
            else
            begin
               errorCount++;
               $display("[ERROR] %s: expected dhit %0b, actual %0b", name,
                        hitMode == EXPECT_HIT, dhit);
            end
         end
         firstLook = 1'b0;
         if (dhit)
         begin
            served = 1'b1;
            if (isWrite)
            begin
               shadow[addr[9:2]] = data;
            end
            else
            begin
               nameQ.push_back(name);
               addrQ.push_back(addr);
               gotQ.push_back(dmemload);
               -> readSampled;
            end
         end
         @(negedge CLK);
      end
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
   endtask

   always
   begin
      string name;
      logic [31:0] addr;
      logic [31:0] got;
      @(readSampled);
      while (gotQ.size() > 0)
      begin
         name = nameQ.pop_front();
         addr = addrQ.pop_front();
         got  = gotQ.pop_front();
         checkCount++;
         assert (got === expectedLoad(addr))
         else
         begin
            errorCount++;
            $display("[ERROR] %s: expected %h, actual %h", name, expectedLoad(addr), got);
         end
      end
   end

   initial
   begin
      wait (cycleCount >= CYCLE_LIMIT);
      $display("timeout waiting for dhit or flushed after %0d cycles", cycleCount);
      $display("checks: %0d, errors: %0d", checkCount, errorCount + 1);
      $display("Test failures found");
      $finish;
   end

   initial
   begin
      void'($urandom(32'h80981ab5));
      nRST      = 1'b0;
      dmemREN   = 1'b0;
      dmemWEN   = 1'b0;
      halt      = 1'b0;
      dmemaddr  = '0;
      dmemstore = '0;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         shadow[i] = ~32'(i);
      end
      repeat (RESET_CYCLES) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;

      // no request yet, so the cache must be quiet
      checkCount++;
      assert ({dhit, dREN, dWEN, flushed} === 4'b0000)
      else
      begin
         errorCount++;
         $display("[ERROR] reset state: expected %b, actual %b", 4'b0000,
                  {dhit, dREN, dWEN, flushed});
      end

      // read miss, repeat read, other word of the block
      issueRequest(1'b0, 32'h100, '0, EXPECT_MISS, "read miss");
      issueRequest(1'b0, 32'h100, '0, EXPECT_HIT, "read hit");
      issueRequest(1'b0, 32'h104, '0, EXPECT_HIT, "read other word");

      // write miss, write hit on dirty and on clean blocks
      issueRequest(1'b1, 32'h200, 32'hcafe0001, EXPECT_MISS, "write miss");
      issueRequest(1'b0, 32'h200, '0, EXPECT_HIT, "read after write miss");
      issueRequest(1'b1, 32'h200, 32'hcafe0002, EXPECT_HIT, "write hit dirty");
      issueRequest(1'b0, 32'h200, '0, EXPECT_HIT, "read after dirty hit");
      issueRequest(1'b0, 32'h288, '0, EXPECT_MISS, "read clean block");
      issueRequest(1'b1, 32'h28c, 32'hcafe0003, EXPECT_HIT, "write hit clean");
      issueRequest(1'b0, 32'h28c, '0, EXPECT_HIT, "read after clean hit");

      // three tags in set 2 force LRU eviction with write-back
      for (int t = 0; t < 3; t++)
      begin
         issueRequest(1'b1, blockAddr(26'(t + 4), 3'd2, 1'b0), 32'hbeef0000 + t,
                      EXPECT_MISS, "set fill");
      end
      for (int r = 0; r < 6; r++)
      begin
         issueRequest(1'b0, blockAddr(26'((r % 3) + 4), 3'd2, 1'b0), '0,
                      EXPECT_MISS, "lru rotation");
      end

      for (int n = 0; n < RANDOM_OPS; n++)
      begin
         randWord = $urandom_range(63, 0);
         randData = $urandom;
         if ($urandom_range(1, 0) == 1)
         begin
            issueRequest(1'b1, randWord << 2, randData, EXPECT_ANY, "random write");
         end
         else
         begin
            issueRequest(1'b0, randWord << 2, '0, EXPECT_ANY, "random read");
         end
      end

      halt = 1'b1;
      while (!flushed)
      begin
         @(negedge CLK);
      end
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         checkCount++;
         assert (memory_i.mem[i] === shadow[i])
         else
         begin
            errorCount++;
            $display("[ERROR] flush word %0d: expected %h, actual %h", i, shadow[i],
                     memory_i.mem[i]);
         end
      end

      // flushed holds and the memory port stays idle
      repeat (4) @(negedge CLK);
      checkCount++;
      assert ({flushed, dhit, dREN, dWEN} === 4'b1000)
      else
      begin
         errorCount++;
         $display("[ERROR] halted state: expected %b, actual %b", 4'b1000,
                  {flushed, dhit, dREN, dWEN});
      end

      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- sim/tbMemory.sv
`timescale 1ns/10ps

module tbMemory
#(
   parameter int WORDS = 256
)
(
   input  logic CLK,
   input  logic nRST,
   input  logic dREN,
   input  logic dWEN,
   input  logic [31:0] daddr,
   input  logic [31:0] dstore,
   output logic [31:0] dload,
   output logic dwait
);

   logic [31:0] mem [WORDS];
   logic [1:0] waitLeft;  // wait cycles left for the current transfer
   logic busy;
   logic [7:0] wordIdx;

   assign busy    = dREN || dWEN;
   assign wordIdx = daddr[9:2];
   assign dload   = mem[wordIdx];
   assign dwait   = busy && (waitLeft != 2'd0);

   // every word starts as its inverted word address
   initial
   begin
      for (int i = 0; i < WORDS; i++)
      begin
         mem[i] = ~32'(i);
      end
   end

   always @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         waitLeft <= '0;
      end
      else if (busy)
      begin
         if (waitLeft != 2'd0)
         begin
            waitLeft <= waitLeft - 1'b1;
         end
         else
         begin
            waitLeft <= 2'($urandom_range(3, 0));  // delay of next transfer
         end
      end
   end

   always @(posedge CLK)
   begin
      if (dWEN && !dwait)
      begin
         mem[wordIdx] <= dstore;
      end
   end

endmodule

//--- verilog/dCache.sv
`timescale 1ns/10ps

module dCache
(
   input  logic CLK,
   input  logic nRST,
   input  logic dmemREN,
   input  logic dmemWEN,
   input  logic halt,
   input  logic [cachePkg::WORD_W-1:0] dmemaddr,
   input  logic [cachePkg::WORD_W-1:0] dmemstore,
   output logic dhit,
   output logic [cachePkg::WORD_W-1:0] dmemload,
   output logic flushed,
   output logic dREN,
   output logic dWEN,
   output logic [cachePkg::WORD_W-1:0] daddr,
   output logic [cachePkg::WORD_W-1:0] dstore,
   input  logic [cachePkg::WORD_W-1:0] dload,
   input  logic dwait
);

   cachePkg::dAddr_u reqAddr;
   logic [cachePkg::IDX_W-1:0] setIdx;
   logic [cachePkg::NUM_WAYS-1:0][cachePkg::TAG_W-1:0] wayTags;
   logic [cachePkg::NUM_WAYS-1:0] wayValid;
   logic [cachePkg::NUM_WAYS-1:0] wayDirty;
   logic [cachePkg::NUM_WAYS-1:0][1:0][cachePkg::WORD_W-1:0] blockData;
   logic leastRecent;
   logic wrEn, wrWay, wrOffset, wrDirty;
   logic [cachePkg::TAG_W-1:0] wrTag;
   logic [cachePkg::WORD_W-1:0] wrData;
   logic clrEn, clrWay, touchEn, touchWay;
   logic hit, hitWay, victimWay;
   logic [cachePkg::WORD_W-1:0] hitData;

   assign reqAddr.raw = dmemaddr;

   cacheArray array_i (.*);

   wayLookup lookup_i
   (
      .reqTag    (reqAddr.fields.tag),
      .reqOffset (reqAddr.fields.blkOff),
      .*
   );

   cacheControl control_i (.*);

endmodule

//--- verilog/cacheControl.sv
`timescale 1ns/10ps

module cacheControl
(
   input  logic CLK,
   input  logic nRST,
   input  logic dmemREN,
   input  logic dmemWEN,
   input  logic halt,
   input  logic [cachePkg::WORD_W-1:0] dmemaddr,
   input  logic [cachePkg::WORD_W-1:0] dmemstore,
   output logic dhit,
   output logic flushed,
   output logic [cachePkg::WORD_W-1:0] dmemload,
   input  logic hit,
   input  logic hitWay,
   input  logic victimWay,
   input  logic [cachePkg::WORD_W-1:0] hitData,
   input  logic [cachePkg::NUM_WAYS-1:0][cachePkg::TAG_W-1:0] wayTags,
   input  logic [cachePkg::NUM_WAYS-1:0] wayValid,
   input  logic [cachePkg::NUM_WAYS-1:0] wayDirty,
   input  logic [cachePkg::NUM_WAYS-1:0][1:0][cachePkg::WORD_W-1:0] blockData,
   output logic [cachePkg::IDX_W-1:0] setIdx,
   output logic wrEn,
   output logic wrWay,
   output logic wrOffset,
   output logic wrDirty,
   output logic [cachePkg::TAG_W-1:0] wrTag,
   output logic [cachePkg::WORD_W-1:0] wrData,
   output logic clrEn,
   output logic clrWay,
   output logic touchEn,
   output logic touchWay,
   output logic dREN,
   output logic dWEN,
   output logic [cachePkg::WORD_W-1:0] daddr,
   output logic [cachePkg::WORD_W-1:0] dstore,
   input  logic [cachePkg::WORD_W-1:0] dload,
   input  logic dwait
);

   logic [ctrlPkg::STATE_W-1:0] state, nextState;
   logic evictWay;
   logic [cachePkg::IDX_W-1:0] flushIdx;
   logic flushWay;
   logic latchVictim;
   logic advance;  // step flush to next block
   logic lastBlock;
   logic flushing;
   logic wbWay;
   logic wbOffset;
   logic [cachePkg::WORD_W-1:0] wbAddr;
   logic [cachePkg::WORD_W-1:0] wbData;
   cachePkg::dAddr_u req;

   assign req.raw   = dmemaddr;
   assign flushing  = (state == ctrlPkg::S_FLUSH1) || (state == ctrlPkg::S_FLUSH2);
   assign setIdx    = flushing ? flushIdx : req.fields.idx;
   assign lastBlock = (flushIdx == ctrlPkg::LAST_SET) && flushWay;
   assign flushed   = (state == ctrlPkg::S_HALTED);
   assign dmemload  = (state == ctrlPkg::S_FETCH2) ? dload : hitData;

   // write-back source, shared by miss eviction and flush
   assign wbWay    = flushing ? flushWay : evictWay;
   assign wbOffset = (state == ctrlPkg::S_WB2) || (state == ctrlPkg::S_FLUSH2);
   assign wbAddr   = {wayTags[wbWay], setIdx, wbOffset, {cachePkg::BYTOFF_W{1'b0}}};
   assign wbData   = blockData[wbWay][wbOffset];

   always_comb
   begin
      nextState   = state;
      latchVictim = 1'b0;
      advance     = 1'b0;
      dhit        = 1'b0;
      dREN        = 1'b0;
      dWEN        = 1'b0;
      daddr       = '0;
      dstore      = '0;
      wrEn        = 1'b0;
      wrWay       = evictWay;
      wrOffset    = req.fields.blkOff;
      wrDirty     = 1'b0;
      wrTag       = req.fields.tag;
      wrData      = dload;
      clrEn       = 1'b0;
      clrWay      = flushWay;
      touchEn     = 1'b0;
      touchWay    = evictWay;
      case (state)
         ctrlPkg::S_IDLE:
         begin
            if (halt)
            begin
               nextState = ctrlPkg::S_FLUSH1;
            end
            else if (dmemREN || dmemWEN)
            begin
               if (hit)
               begin
                  dhit     = 1'b1;
                  touchEn  = 1'b1;
                  touchWay = hitWay;
                  wrEn     = dmemWEN;  // write hit lands in place
                  wrWay    = hitWay;
                  wrDirty  = 1'b1;
                  wrData   = dmemstore;
               end
               else
               begin
                  latchVictim = 1'b1;
                  if (wayValid[victimWay] && wayDirty[victimWay])
                  begin
                     nextState = ctrlPkg::S_WB1;
                  end
                  else
                  begin
                     nextState = ctrlPkg::S_FETCH1;
                  end
               end
            end
         end
         ctrlPkg::S_WB1, ctrlPkg::S_WB2:
         begin
            dWEN   = 1'b1;
            daddr  = wbAddr;
            dstore = wbData;
            if (!dwait)
            begin
               nextState = wbOffset ? ctrlPkg::S_FETCH1 : ctrlPkg::S_WB2;
            end
         end
         ctrlPkg::S_FETCH1:
         begin
            dREN     = 1'b1;
            daddr    = {req.fields.tag, req.fields.idx, ~req.fields.blkOff,
                        {cachePkg::BYTOFF_W{1'b0}}};
            wrOffset = ~req.fields.blkOff;
            if (!dwait)
            begin
               wrEn      = 1'b1;
               nextState = ctrlPkg::S_FETCH2;
            end
         end
         ctrlPkg::S_FETCH2:
         begin
            dREN    = 1'b1;
            daddr   = {req.fields.tag, req.fields.idx, req.fields.blkOff,
                       {cachePkg::BYTOFF_W{1'b0}}};
            wrDirty = dmemWEN;
            wrData  = dmemWEN ? dmemstore : dload;  // write miss merges store
            if (!dwait)
            begin
               wrEn      = 1'b1;
               dhit      = 1'b1;
               touchEn   = 1'b1;
               nextState = ctrlPkg::S_IDLE;
            end
         end
         ctrlPkg::S_FLUSH1:
         begin
            if (wayValid[flushWay] && wayDirty[flushWay])
            begin
               dWEN   = 1'b1;
               daddr  = wbAddr;
               dstore = wbData;
               if (!dwait)
               begin
                  nextState = ctrlPkg::S_FLUSH2;
               end
            end
            else
            begin
               clrEn     = 1'b1;
               advance   = 1'b1;
               nextState = lastBlock ? ctrlPkg::S_HALTED : ctrlPkg::S_FLUSH1;
            end
         end
         ctrlPkg::S_FLUSH2:
         begin
            dWEN   = 1'b1;
            daddr  = wbAddr;
            dstore = wbData;
            if (!dwait)
            begin
               clrEn     = 1'b1;
               advance   = 1'b1;
               nextState = lastBlock ? ctrlPkg::S_HALTED : ctrlPkg::S_FLUSH1;
            end
         end
         ctrlPkg::S_HALTED:
         begin
            nextState = ctrlPkg::S_HALTED;  // held until reset
         end
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state    <= ctrlPkg::S_IDLE;
         evictWay <= 1'b0;
         flushIdx <= '0;
         flushWay <= 1'b0;
      end
      else
      begin
         state <= nextState;
         if (latchVictim)
         begin
            evictWay <= victimWay;
         end
         if (advance)
         begin
            flushWay <= ~flushWay;
            if (flushWay)
            begin
               flushIdx <= flushIdx + 1'b1;
            end
         end
      end
   end

endmodule

//--- verilog/wayLookup.sv
`timescale 1ns/10ps

module wayLookup
(
   input  logic [cachePkg::TAG_W-1:0] reqTag,
   input  logic reqOffset,
   input  logic [cachePkg::NUM_WAYS-1:0][cachePkg::TAG_W-1:0] wayTags,
   input  logic [cachePkg::NUM_WAYS-1:0] wayValid,
   input  logic [cachePkg::NUM_WAYS-1:0][1:0][cachePkg::WORD_W-1:0] blockData,
   input  logic leastRecent,
   output logic hit,
   output logic hitWay,
   output logic victimWay,
   output logic [cachePkg::WORD_W-1:0] hitData
);

   logic [cachePkg::NUM_WAYS-1:0] match;

   assign match[0] = wayValid[0] && (wayTags[0] == reqTag);
   assign match[1] = wayValid[1] && (wayTags[1] == reqTag);

   assign hit     = |match;
   assign hitWay  = !match[0];  // way 1 only when way 0 misses
   assign hitData = blockData[hitWay][reqOffset];

   // fill an empty way first, way 0 before way 1
   always_comb
   begin
      if (!wayValid[0])
      begin
         victimWay = 1'b0;
      end
      else if (!wayValid[1])
      begin
         victimWay = 1'b1;
      end
      else
      begin
         victimWay = leastRecent;
      end
   end

endmodule

//--- verilog/cacheArray.sv
`timescale 1ns/10ps

module cacheArray
(
   input  logic CLK,
   input  logic nRST,
   input  logic [cachePkg::IDX_W-1:0] setIdx,
   output logic [cachePkg::NUM_WAYS-1:0][cachePkg::TAG_W-1:0] wayTags,
   output logic [cachePkg::NUM_WAYS-1:0] wayValid,
   output logic [cachePkg::NUM_WAYS-1:0] wayDirty,
   output logic [cachePkg::NUM_WAYS-1:0][1:0][cachePkg::WORD_W-1:0] blockData,
   output logic leastRecent,
   input  logic wrEn,
   input  logic wrWay,
   input  logic wrOffset,
   input  logic wrDirty,
   input  logic [cachePkg::TAG_W-1:0] wrTag,
   input  logic [cachePkg::WORD_W-1:0] wrData,
   input  logic clrEn,
   input  logic clrWay,
   input  logic touchEn,
   input  logic touchWay
);

   logic [cachePkg::NUM_WAYS-1:0][cachePkg::TAG_W-1:0] tags [cachePkg::NUM_SETS];
   logic [cachePkg::NUM_WAYS-1:0][1:0][cachePkg::WORD_W-1:0] data [cachePkg::NUM_SETS];
   logic [cachePkg::NUM_WAYS-1:0] valid [cachePkg::NUM_SETS];
   logic [cachePkg::NUM_WAYS-1:0] dirty [cachePkg::NUM_SETS];
   logic [cachePkg::NUM_SETS-1:0] lru;  // way to evict next, per set

   // combinational read of the addressed set
   assign wayTags     = tags[setIdx];
   assign blockData   = data[setIdx];
   assign wayValid    = valid[setIdx];
   assign wayDirty    = dirty[setIdx];
   assign leastRecent = lru[setIdx];

   always_ff @(posedge CLK)
   begin
      if (wrEn)
      begin
         tags[setIdx][wrWay]           <= wrTag;
         data[setIdx][wrWay][wrOffset] <= wrData;
      end
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid <= '{default: '0};
         dirty <= '{default: '0};
         lru   <= '0;
      end
      else
      begin
         if (wrEn)
         begin
            valid[setIdx][wrWay] <= 1'b1;
            dirty[setIdx][wrWay] <= wrDirty;
         end
         if (clrEn)
         begin
            valid[setIdx][clrWay] <= 1'b0;
            dirty[setIdx][clrWay] <= 1'b0;
         end
         if (touchEn)
         begin
            lru[setIdx] <= ~touchWay;  // other way becomes least recent
         end
      end
   end

endmodule

//--- verilog/ctrlPkg.sv
package ctrlPkg;

   localparam int STATE_W = 3;

   localparam logic [STATE_W-1:0] S_IDLE   = 3'd0;
   localparam logic [STATE_W-1:0] S_WB1    = 3'd1;  // victim word 0 out
   localparam logic [STATE_W-1:0] S_WB2    = 3'd2;
   localparam logic [STATE_W-1:0] S_FETCH1 = 3'd3;  // other word of block
   localparam logic [STATE_W-1:0] S_FETCH2 = 3'd4;  // requested word
   localparam logic [STATE_W-1:0] S_FLUSH1 = 3'd5;
   localparam logic [STATE_W-1:0] S_FLUSH2 = 3'd6;
   localparam logic [STATE_W-1:0] S_HALTED = 3'd7;

   // last set visited by the halt flush
   localparam logic [cachePkg::IDX_W-1:0] LAST_SET = 3'd7;

endpackage

//--- verilog/cachePkg.sv
package cachePkg;

   localparam int WORD_W   = 32;
   localparam int BYTOFF_W = 2;
   localparam int BLKOFF_W = 1;  // two words per block
   localparam int IDX_W    = 3;
   localparam int TAG_W    = WORD_W - IDX_W - BLKOFF_W - BYTOFF_W;
   localparam int NUM_SETS = 1 << IDX_W;
   localparam int NUM_WAYS = 2;

   // one address word, raw or split into its cache fields
   typedef union packed
   {
      logic [WORD_W-1:0] raw;
      struct packed
      {
         logic [TAG_W-1:0]    tag;
         logic [IDX_W-1:0]    idx;
         logic [BLKOFF_W-1:0] blkOff;
         logic [BYTOFF_W-1:0] bytOff;
      } fields;
   } dAddr_u;

endpackage
